/* src/shift_settings.svh */
// Shift unit settings.
// Operand, count and lane widths shared by the package, RTL and testbench.

`ifndef SHIFT_SETTINGS_SVH
`define SHIFT_SETTINGS_SVH

// Operand and result width in bits.
`define SHIFT_DATA_W 64

// Shift count width, enough for a 64-bit operand.
`define SHIFT_CNT_W 6

// Number of byte lanes in one operand.
`define SHIFT_LANES 8

`endif

/* src/shift_pkg.sv */
// Shift unit package.
// Word, count and flag types plus the operation and operand size encodings.

`include "shift_settings.svh"

package shift_pkg;

  // ------------------------------
  // Data types
  // ------------------------------

  typedef logic [`SHIFT_DATA_W-1:0] shift_word_t;
  typedef logic [`SHIFT_CNT_W-1:0] shift_cnt_t;

  // Carry at the top, then zero, then sign.
  typedef logic [2:0] shift_flags_t;

  localparam int FLAG_CARRY = 2;
  localparam int FLAG_ZERO = 1;
  localparam int FLAG_SIGN = 0;

  // ------------------------------
  // Micro-op encodings
  // ------------------------------

  typedef enum logic [1:0] {
    SHIFT_SHL = 2'd0,
    SHIFT_SHR = 2'd1,
    SHIFT_SAR = 2'd2
  } shift_op_e;

  typedef enum logic [1:0] {
    SIZE_8  = 2'd0,
    SIZE_32 = 2'd1,
    SIZE_64 = 2'd2
  } shift_size_e;

endpackage

/* src/shift_op_if.sv */
// Decoded shift operation bus.
// Carries one issued micro-op from decode to the shifters and write-back.

`timescale 1ns/100ps

interface shift_op_if (
  input logic clk
);
  import shift_pkg::*;

  // One-cycle strobe per operation; the other fields are valid with it.
  logic        valid;
  // High for a right shift.
  logic        dir;
  // High when the vacated bits take the sign.
  logic        arith;
  shift_size_e size;
  shift_word_t operand;
  // Count already masked to the operand size.
  shift_cnt_t  count;

  modport src (
    output valid, dir, arith, size, operand, count
  );

  // The clock is only used by the shifter checks.
  modport shf (
    input clk, valid, dir, arith, size, operand, count
  );

  modport wb (
    input valid, size
  );

endinterface

/* src/shift_decode.sv */
// Shift micro-op decode.
// Registers the issued op, masks the count and derives direction and fill mode.

`timescale 1ns/100ps

module shift_decode (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  in_valid,
  input  shift_pkg::shift_op_e   in_op,
  input  shift_pkg::shift_size_e in_size,
  input  shift_pkg::shift_word_t in_operand,
  input  shift_pkg::shift_cnt_t  in_count,
  shift_op_if.src               op
);
  import shift_pkg::*;

  shift_cnt_t cnt_masked;
  logic       dir_next;
  logic       arith_next;

  // ------------------------------
  // Count mask and op decode
  // ------------------------------

  // Only the bits that address the operand width take part in the shift.
  always_comb begin
    case (in_size)
      SIZE_8:  cnt_masked = {3'b000, in_count[2:0]};
      SIZE_32: cnt_masked = {1'b0, in_count[4:0]};
      default: cnt_masked = in_count;
    endcase
  end

  always_comb begin
    case (in_op)
      SHIFT_SHR: begin
        dir_next   = 1'b1;
        arith_next = 1'b0;
      end
      SHIFT_SAR: begin
        dir_next   = 1'b1;
        arith_next = 1'b1;
      end
      default: begin
        dir_next   = 1'b0;
        arith_next = 1'b0;
      end
    endcase
  end

  // ------------------------------
  // Issue register
  // ------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      op.valid <= 1'b0;
    end else begin
      op.valid <= in_valid;
    end
  end

  // Payload is only captured with a valid op.
  always_ff @(posedge clk) begin
    if (in_valid) begin
      op.dir     <= dir_next;
      op.arith   <= arith_next;
      op.size    <= in_size;
      op.operand <= in_operand;
      op.count   <= cnt_masked;
    end
  end

  // An issued op must carry one of the three defined encodings.
  a_op_known: assert property (@(posedge clk) disable iff (!rst_n)
    in_valid |-> !$isunknown(in_op) && (in_op inside {SHIFT_SHL, SHIFT_SHR, SHIFT_SAR}));

endmodule

/* src/shlr_wide.sv */
// Wide shifter for 32 and 64-bit operands.
// A byte-lane stage followed by a bit stage, with fill and carry-out.

`timescale 1ns/100ps
`include "shift_settings.svh"

module shlr_wide (
  shift_op_if.shf               op,
  output shift_pkg::shift_word_t wide_res,
  output logic                  wide_carry
);
  import shift_pkg::*;

  logic        is64;
  logic        fill_bit;
  shift_word_t val_p0;
  logic [2:0]  lane_cnt;
  logic [2:0]  bit_cnt;
  shift_word_t lane_out;
  logic [`SHIFT_DATA_W+15:0] win;
  shift_word_t bit_res;
  logic        lane_carry_r;
  logic        lane_carry_l;

  assign is64     = (op.size == SIZE_64);
  assign lane_cnt = op.count[5:3];
  assign bit_cnt  = op.count[2:0];

  // Arithmetic shifts fill from the sign of the active width.
  assign fill_bit = op.arith & (is64 ? op.operand[63] : op.operand[31]);

  // A 32-bit operand sees fill in its upper half, so a right shift
  // pulls sign or zero bits down into the result.
  assign val_p0 = {is64 ? op.operand[63:32] : {32{fill_bit}}, op.operand[31:0]};

  // ------------------------------
  // Byte-lane stage
  // ------------------------------

  always_comb begin : lane_stage
    int src;
    for (int l = 0; l < `SHIFT_LANES; l++) begin
      src = op.dir ? l + int'(lane_cnt) : l - int'(lane_cnt);
      if (src >= 0 && src < `SHIFT_LANES) begin
        lane_out[l*8 +: 8] = val_p0[src*8 +: 8];
      end else begin
        lane_out[l*8 +: 8] = {8{fill_bit}};
      end
    end
  end

  // Carry when the whole move is in whole bytes.
  always_comb begin
    if (lane_cnt == 3'd0) begin
      lane_carry_r = 1'b0;
      lane_carry_l = 1'b0;
    end else begin
      lane_carry_r = val_p0[8 * int'(lane_cnt) - 1];
      if (is64) begin
        lane_carry_l = val_p0[64 - 8 * int'(lane_cnt)];
      end else begin
        lane_carry_l = val_p0[32 - 8 * int'(lane_cnt)];
      end
    end
  end

  // ------------------------------
  // Bit stage
  // ------------------------------

  // Guard bytes on both sides hold the fill bit, so the window never
  // reads past the lane result.
  assign win = {{8{fill_bit}}, lane_out, {8{fill_bit}}};

  always_comb begin
    if (op.dir) begin
      bit_res = win[8 + bit_cnt +: `SHIFT_DATA_W];
    end else begin
      bit_res = win[8 - bit_cnt +: `SHIFT_DATA_W];
    end
  end

  assign wide_res = is64 ? bit_res : {32'b0, bit_res[31:0]};

  // The carry is the last bit to leave the active width.
  always_comb begin
    if (op.count == '0) begin
      wide_carry = 1'b0;
    end else if (op.dir) begin
      wide_carry = (bit_cnt == 3'd0) ? lane_carry_r : win[8 + bit_cnt - 1];
    end else if (bit_cnt == 3'd0) begin
      wide_carry = lane_carry_l;
    end else if (is64) begin
      wide_carry = win[72 - bit_cnt];
    end else begin
      wide_carry = win[40 - bit_cnt];
    end
  end

endmodule

/* src/shlr_byte.sv */
// Byte shifter.
// Shifts the low operand byte by up to 7 bits with sign fill and carry-out.

`timescale 1ns/100ps

module shlr_byte (
  shift_op_if.shf    op,
  output logic [7:0] byte_res,
  output logic       byte_carry
);
  import shift_pkg::*;

  logic        fill_bit;
  logic [2:0]  sh;
  logic [23:0] win;

  assign fill_bit = op.arith & op.operand[7];
  assign sh       = op.count[2:0];

  // The byte sits in the middle, with a fill byte on each side.
  assign win = {{8{fill_bit}}, op.operand[7:0], {8{fill_bit}}};

  always_comb begin
    if (op.dir) begin
      byte_res = win[8 + sh +: 8];
    end else begin
      byte_res = win[8 - sh +: 8];
    end
  end

  always_comb begin
    if (sh == 3'd0) begin
      byte_carry = 1'b0;
    end else if (op.dir) begin
      byte_carry = op.operand[sh - 3'd1];
    end else begin
      byte_carry = op.operand[4'd8 - {1'b0, sh}];
    end
  end

  // Decode must have masked a byte count down to three bits.
  a_byte_cnt_masked: assert property (@(posedge op.clk)
    op.valid && (op.size == SIZE_8) |-> op.count[5:3] == 3'b000);

endmodule

/* src/shift_flags_wb.sv */
// Shift result write-back.
// Selects the result by size, forms carry, zero and sign, and registers them.

`timescale 1ns/100ps
`include "shift_settings.svh"

module shift_flags_wb (
  input  logic                   clk,
  input  logic                   rst_n,
  shift_op_if.wb                 op,
  input  shift_pkg::shift_word_t  wide_res,
  input  logic                   wide_carry,
  input  logic [7:0]             byte_res,
  input  logic                   byte_carry,
  output logic                   out_valid,
  output shift_pkg::shift_word_t  out_result,
  output shift_pkg::shift_flags_t out_flags
);
  import shift_pkg::*;

  shift_word_t  sel_res;
  logic         sel_carry;
  logic         sel_sign;
  shift_flags_t flags_next;

  // ------------------------------
  // Result select and flags
  // ------------------------------

  // Byte results are zero-extended to the full word.
  always_comb begin
    case (op.size)
      SIZE_8: begin
        sel_res   = {{(`SHIFT_DATA_W-8){1'b0}}, byte_res};
        sel_carry = byte_carry;
        sel_sign  = byte_res[7];
      end
      SIZE_32: begin
        sel_res   = wide_res;
        sel_carry = wide_carry;
        sel_sign  = wide_res[31];
      end
      default: begin
        sel_res   = wide_res;
        sel_carry = wide_carry;
        sel_sign  = wide_res[`SHIFT_DATA_W-1];
      end
    endcase
  end

  always_comb begin
    flags_next[FLAG_CARRY] = sel_carry;
    flags_next[FLAG_ZERO]  = (sel_res == '0);
    flags_next[FLAG_SIGN]  = sel_sign;
  end

  // ------------------------------
  // Output register
  // ------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid  <= 1'b0;
      out_result <= '0;
      out_flags  <= '0;
    end else begin
      out_valid <= op.valid;
      // Hold the last result between operations.
      if (op.valid) begin
        out_result <= sel_res;
        out_flags  <= flags_next;
      end
    end
  end

  // The output strobe is the decoded strobe delayed by exactly one cycle.
  a_wb_follows: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid == $past(op.valid));

endmodule

/* src/shift_unit_top.sv */
// Integer shift unit top level.
// Decode, the wide and byte shifters, and flag write-back, two cycles deep.

`timescale 1ns/100ps

module shift_unit_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   in_valid,
  input  shift_pkg::shift_op_e    in_op,
  input  shift_pkg::shift_size_e  in_size,
  input  shift_pkg::shift_word_t  in_operand,
  input  shift_pkg::shift_cnt_t   in_count,
  output logic                   out_valid,
  output shift_pkg::shift_word_t  out_result,
  output shift_pkg::shift_flags_t out_flags
);
  import shift_pkg::*;

  shift_word_t wide_res;
  logic        wide_carry;
  logic [7:0]  byte_res;
  logic        byte_carry;

  // Decoded op shared by the shifters and write-back.
  shift_op_if u_op_if (.clk(clk));

  shift_decode u_decode (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_op      (in_op),
    .in_size    (in_size),
    .in_operand (in_operand),
    .in_count   (in_count),
    .op         (u_op_if.src)
  );

  shlr_wide u_shlr_wide (
    .op         (u_op_if.shf),
    .wide_res   (wide_res),
    .wide_carry (wide_carry)
  );

  shlr_byte u_shlr_byte (
    .op         (u_op_if.shf),
    .byte_res   (byte_res),
    .byte_carry (byte_carry)
  );

  shift_flags_wb u_flags_wb (
    .clk        (clk),
    .rst_n      (rst_n),
    .op         (u_op_if.wb),
    .wide_res   (wide_res),
    .wide_carry (wide_carry),
    .byte_res   (byte_res),
    .byte_carry (byte_carry),
    .out_valid  (out_valid),
    .out_result (out_result),
    .out_flags  (out_flags)
  );

endmodule

/* test/shift_tb.sv */
// Shift unit testbench.
// Directed and random shift tests checked against a reference model of the shift rules.

`timescale 1ns/100ps
`include "shift_settings.svh"

module shift_tb;
  import shift_pkg::*;

  // Reset 10 cycles, 27 directed ops at 2 cycles each and 53 cycles of
  // back-to-back traffic stay far below this.
  localparam int MAX_CYCLES = 2000;

  logic         clk;
  logic         rst_n;
  logic         in_valid;
  shift_op_e    in_op;
  shift_size_e  in_size;
  shift_word_t  in_operand;
  shift_cnt_t   in_count;
  logic         out_valid;
  shift_word_t  out_result;
  shift_flags_t out_flags;

  logic [31:0]  lfsr_state;
  int           cycle_count;

  shift_unit_top u_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_op      (in_op),
    .in_size    (in_size),
    .in_operand (in_operand),
    .in_count   (in_count),
    .out_valid  (out_valid),
    .out_result (out_result),
    .out_flags  (out_flags)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: the run went past %0d clock cycles without finishing", MAX_CYCLES);
      $display("FAIL: see errors above");
      $fatal(1);
    end
  end

  // ------------------------------
  // Stimulus and reference model
  // ------------------------------

  // Galois LFSR with the polynomial x^32 + x^22 + x^2 + x + 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  function automatic shift_word_t take_bits(input int n);
    shift_word_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[`SHIFT_DATA_W-2:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // Expected result and flags from the shift rules of the unit.
  function automatic void model_shift(input shift_op_e o, input shift_size_e s,
                                      input shift_word_t d, input shift_cnt_t c,
                                      output shift_word_t res, output shift_flags_t flags);
    int          w;
    int          n;
    shift_word_t mask;
    shift_word_t val;
    shift_word_t sext;
    logic        carry;
    case (s)
      SIZE_8:  w = 8;
      SIZE_32: w = 32;
      default: w = 64;
    endcase
    n    = int'(c) & (w - 1);
    mask = (w == 64) ? '1 : ((64'd1 << w) - 64'd1);
    val  = d & mask;
    sext = val[w-1] ? (val | ~mask) : val;
    case (o)
      SHIFT_SHL: begin
        res   = (val << n) & mask;
        carry = (n == 0) ? 1'b0 : val[w-n];
      end
      SHIFT_SHR: begin
        res   = val >> n;
        carry = (n == 0) ? 1'b0 : val[n-1];
      end
      default: begin
        res   = shift_word_t'($signed(sext) >>> n) & mask;
        carry = (n == 0) ? 1'b0 : val[n-1];
      end
    endcase
    flags = {carry, (res == '0), res[w-1]};
  endfunction

  // ------------------------------
  // Compare tasks
  // ------------------------------

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAIL t=%0t %s got %b expected %b", $time, name, got, exp);
      $display("FAIL: see errors above");
      $fatal(1);
    end
  endtask

  task automatic check_word(input string name, input shift_word_t got, input shift_word_t exp);
    if (got !== exp) begin
      $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
      $display("FAIL: see errors above");
      $fatal(1);
    end
  endtask

  task automatic check_flags(input string name, input shift_flags_t got,
                             input shift_flags_t exp);
    if (got !== exp) begin
      $display("FAIL t=%0t %s got %b expected %b", $time, name, got, exp);
      $display("FAIL: see errors above");
      $fatal(1);
    end
  endtask

  // ------------------------------
  // Drivers and tests
  // ------------------------------

  // Called 1 ns after a rising edge; the op is sampled on the next edge.
  task automatic drive_op(input shift_op_e o, input shift_size_e s,
                          input shift_word_t d, input shift_cnt_t c);
    in_valid   = 1'b1;
    in_op      = o;
    in_size    = s;
    in_operand = d;
    in_count   = c;
  endtask

  // Issues one op and checks it on the cycle where it must appear.
  task automatic run_one(input shift_op_e o, input shift_size_e s,
                         input shift_word_t d, input shift_cnt_t c);
    shift_word_t  exp_res;
    shift_flags_t exp_flags;
    model_shift(o, s, d, c, exp_res, exp_flags);
    drive_op(o, s, d, c);
    @(posedge clk);
    #1 in_valid = 1'b0;
    @(posedge clk);
    #1;
    check_bit("out_valid", out_valid, 1'b1);
    check_word("out_result", out_result, exp_res);
    check_flags("out_flags", out_flags, exp_flags);
  endtask

  task automatic test_reset_state();
    repeat (3) @(posedge clk);
    #1;
    check_bit("out_valid", out_valid, 1'b0);
    check_word("out_result", out_result, '0);
    check_flags("out_flags", out_flags, '0);
  endtask

  task automatic test_shift_left();
    run_one(SHIFT_SHL, SIZE_8, 64'hFFFF_0000_1234_00A5, 6'd1);
    run_one(SHIFT_SHL, SIZE_8, 64'h0000_0000_0000_00A5, 6'd3);
    run_one(SHIFT_SHL, SIZE_8, 64'h0000_0000_0000_00C3, 6'd7);
    run_one(SHIFT_SHL, SIZE_32, 64'hDEAD_BEEF_8123_4567, 6'd1);
    run_one(SHIFT_SHL, SIZE_32, 64'hDEAD_BEEF_8123_4567, 6'd9);
    run_one(SHIFT_SHL, SIZE_32, 64'hDEAD_BEEF_8123_4567, 6'd31);
    run_one(SHIFT_SHL, SIZE_64, 64'h8123_4567_89AB_CDEF, 6'd1);
    run_one(SHIFT_SHL, SIZE_64, 64'h8123_4567_89AB_CDEF, 6'd17);
    run_one(SHIFT_SHL, SIZE_64, 64'h8123_4567_89AB_CDEF, 6'd40);
    run_one(SHIFT_SHL, SIZE_64, 64'h8123_4567_89AB_CDEF, 6'd63);
  endtask

  task automatic test_shift_right();
    run_one(SHIFT_SHR, SIZE_8, 64'h0000_0000_0000_0096, 6'd2);
    run_one(SHIFT_SAR, SIZE_8, 64'h0000_0000_0000_0096, 6'd2);
    run_one(SHIFT_SAR, SIZE_8, 64'hFFFF_FFFF_FFFF_FF35, 6'd5);
    run_one(SHIFT_SHR, SIZE_32, 64'h1234_5678_F000_0F01, 6'd12);
    run_one(SHIFT_SAR, SIZE_32, 64'h1234_5678_F000_0F01, 6'd12);
    run_one(SHIFT_SAR, SIZE_32, 64'hFFFF_FFFF_7000_0F01, 6'd25);
    run_one(SHIFT_SHR, SIZE_64, 64'hC000_0000_0000_8001, 6'd16);
    run_one(SHIFT_SAR, SIZE_64, 64'hC000_0000_0000_8001, 6'd16);
    run_one(SHIFT_SAR, SIZE_64, 64'hC000_0000_0000_8001, 6'd63);
    run_one(SHIFT_SAR, SIZE_64, 64'h4000_0000_0000_8001, 6'd35);
  endtask

  task automatic test_count_mask();
    // Counts of 8, 32 and 0 mask down to zero and leave the operand as it is.
    run_one(SHIFT_SHL, SIZE_8, 64'hABCD_0000_0000_00E7, 6'd8);
    run_one(SHIFT_SAR, SIZE_32, 64'h5555_5555_8765_4321, 6'd32);
    run_one(SHIFT_SHR, SIZE_64, 64'h8765_4321_0FED_CBA9, 6'd0);
    // Counts above the size wrap to their low bits.
    run_one(SHIFT_SHR, SIZE_8, 64'h0000_0000_0000_00F0, 6'd12);
    run_one(SHIFT_SHL, SIZE_32, 64'h0000_0000_0000_0001, 6'd63);
    // Results that are zero set the zero flag.
    run_one(SHIFT_SHL, SIZE_8, 64'h0000_0000_0000_0080, 6'd1);
    run_one(SHIFT_SHR, SIZE_64, 64'h0000_0000_0000_0000, 6'd5);
  endtask

  task automatic test_back_to_back();
    shift_word_t  exp_res [50];
    shift_flags_t exp_flags [50];
    shift_op_e    o;
    shift_size_e  s;
    shift_word_t  d;
    shift_cnt_t   c;
    @(posedge clk);
    #1;
    for (int k = 0; k < 52; k++) begin
      if (k >= 2) begin
        check_bit($sformatf("out_valid[%0d]", k - 2), out_valid, 1'b1);
        check_word($sformatf("out_result[%0d]", k - 2), out_result, exp_res[k-2]);
        check_flags($sformatf("out_flags[%0d]", k - 2), out_flags, exp_flags[k-2]);
      end else begin
        check_bit("out_valid", out_valid, 1'b0);
      end
      if (k < 50) begin
        case (take_bits(2))
          0:       o = SHIFT_SHL;
          1:       o = SHIFT_SHR;
          default: o = SHIFT_SAR;
        endcase
        case (take_bits(2))
          0:       s = SIZE_8;
          1:       s = SIZE_32;
          default: s = SIZE_64;
        endcase
        d = take_bits(64);
        c = shift_cnt_t'(take_bits(6));
        model_shift(o, s, d, c, exp_res[k], exp_flags[k]);
        drive_op(o, s, d, c);
      end else begin
        in_valid = 1'b0;
      end
      @(posedge clk);
      #1;
    end
    check_bit("out_valid", out_valid, 1'b0);
  endtask

  initial begin
    rst_n       = 1'b0;
    in_valid    = 1'b0;
    in_op       = SHIFT_SHL;
    in_size     = SIZE_8;
    in_operand  = '0;
    in_count    = '0;
    lfsr_state  = 32'ha82;
    cycle_count = 0;
    repeat (10) @(posedge clk);
    #1 rst_n = 1'b1;

    test_reset_state();
    test_shift_left();
    test_shift_right();
    test_count_mask();
    test_back_to_back();

    $display("PASS: all tests");
    $finish;
  end

endmodule

/* list.f */
+incdir+src
src/shift_pkg.sv
src/shift_op_if.sv
src/shift_decode.sv
src/shlr_wide.sv
src/shlr_byte.sv
src/shift_flags_wb.sv
src/shift_unit_top.sv
test/shift_tb.sv
